// ==== source/jtag_cfg.svh ====
// JTAG TAP configuration
`ifndef JTAG_CFG_SVH
`define JTAG_CFG_SVH

// instruction register width in bits.
`define JTAG_IR_WIDTH 4

// IDCODE fields, packed as version, part, manufacturer, then a 1.
`define JTAG_IDCODE_VERSION 4'h1
`define JTAG_IDCODE_PART 16'hbabe
`define JTAG_IDCODE_MANUFACTURER 11'h001

// flops between the pins and the edge detector.
`define JTAG_SYNC_STAGES 2

`endif

// ==== source/jtag_tap_pkg.sv ====
// JTAG TAP controller types
package jtag_tap_pkg;

	// standard controller states, with the encoding from the 1149.1 annex.
	typedef enum logic [3:0] {
		EXIT2_DR = 4'h0,
		EXIT1_DR = 4'h1,
		SHIFT_DR = 4'h2,
		PAUSE_DR = 4'h3,
		SELECT_IR_SCAN = 4'h4,
		UPDATE_DR = 4'h5,
		CAPTURE_DR = 4'h6,
		SELECT_DR_SCAN = 4'h7,
		EXIT2_IR = 4'h8,
		EXIT1_IR = 4'h9,
		SHIFT_IR = 4'ha,
		PAUSE_IR = 4'hb,
		RUN_TEST_IDLE = 4'hc,
		UPDATE_IR = 4'hd,
		CAPTURE_IR = 4'he,
		TEST_LOGIC_RESET = 4'hf
	} tap_state_t;

endpackage

// ==== source/jtag_instr_pkg.sv ====
// JTAG instruction definitions
`include "jtag_cfg.svh"

package jtag_instr_pkg;

	// supported opcodes. anything else decodes to BYPASS.
	typedef enum logic [`JTAG_IR_WIDTH-1:0] {
		IDCODE = 'h5,
		USERCODE = 'hc,
		BYPASS = 'hf
	} instr_t;

	// fixed pattern loaded at Capture-IR, LSB shifted out first.
	localparam logic [`JTAG_IR_WIDTH-1:0] IR_CAPTURE = 'b0001;

endpackage

// ==== source/jtag_pin_sync.sv ====
// JTAG pin synchroniser
`timescale 1ns/1ps
`include "jtag_cfg.svh"

module jtag_pin_sync (
	input logic i_clock,
	input logic i_reset,
	input logic tck,
	input logic tms,
	input logic tdi,
	output logic tck_rise,
	output logic tck_fall,
	output logic tms_s,
	output logic tdi_s
);
	logic [`JTAG_SYNC_STAGES-1:0] tck_sync;
	logic [`JTAG_SYNC_STAGES-1:0] tms_sync;
	logic [`JTAG_SYNC_STAGES-1:0] tdi_sync;
	logic tck_hist; // one more tck flop, the older half of the edge history.

	// all three pins go through the same depth.
	always_ff @(posedge i_clock) begin
		tck_sync <= {tck_sync[`JTAG_SYNC_STAGES-2:0], tck};
		tms_sync <= {tms_sync[`JTAG_SYNC_STAGES-2:0], tms};
		tdi_sync <= {tdi_sync[`JTAG_SYNC_STAGES-2:0], tdi};
		tms_s <= tms_sync[`JTAG_SYNC_STAGES-1]; // lines up with the strobes.
		tdi_s <= tdi_sync[`JTAG_SYNC_STAGES-1];
	end

	// during reset the history just tracks the pin, so no stale edge fires after it.
	always_ff @(posedge i_clock) begin
		tck_hist <= tck_sync[`JTAG_SYNC_STAGES-1];
		if (i_reset) begin
			tck_rise <= 1'b0;
			tck_fall <= 1'b0;
		end else begin
			tck_rise <= tck_sync[`JTAG_SYNC_STAGES-1] & ~tck_hist; // 01 history.
			tck_fall <= ~tck_sync[`JTAG_SYNC_STAGES-1] & tck_hist; // 10 history.
		end
	end

endmodule

// ==== source/jtag_tap_fsm.sv ====
// JTAG TAP controller
`timescale 1ns/1ps

module jtag_tap_fsm (
	input logic i_clock,
	input logic i_reset,
	input logic tck_rise,
	input logic tms_s,
	output logic tlr,
	output logic capture_ir,
	output logic shift_ir,
	output logic update_ir,
	output logic capture_dr,
	output logic shift_dr,
	output logic update_dr,
	output logic ir_path
);
	import jtag_tap_pkg::*;

	tap_state_t state;
	tap_state_t state_next;

	// standard TMS transition table.
	always_comb begin
		case (state)
			TEST_LOGIC_RESET: state_next = tms_s ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE: state_next = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN: state_next = tms_s ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR: state_next = tms_s ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR: state_next = tms_s ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR: state_next = tms_s ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR: state_next = tms_s ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR: state_next = tms_s ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR: state_next = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN: state_next = tms_s ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR: state_next = tms_s ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR: state_next = tms_s ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR: state_next = tms_s ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR: state_next = tms_s ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR: state_next = tms_s ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR: state_next = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			default: state_next = TEST_LOGIC_RESET;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= TEST_LOGIC_RESET;
		end else if (tck_rise) begin
			state <= state_next;
		end
	end

	// actions fire on the rising edge that leaves the state.
	assign tlr = tck_rise && (state == TEST_LOGIC_RESET);
	assign capture_ir = tck_rise && (state == CAPTURE_IR);
	assign shift_ir = tck_rise && (state == SHIFT_IR); // the exit edge shifts too.
	assign update_ir = tck_rise && (state == UPDATE_IR);
	assign capture_dr = tck_rise && (state == CAPTURE_DR);
	assign shift_dr = tck_rise && (state == SHIFT_DR);
	assign update_dr = tck_rise && (state == UPDATE_DR);

	// level for the falling-edge tdo mux.
	assign ir_path = (state == SHIFT_IR);

endmodule

// ==== source/jtag_instr_reg.sv ====
// JTAG instruction register
`timescale 1ns/1ps
`include "jtag_cfg.svh"

module jtag_instr_reg (
	input logic i_clock,
	input logic i_reset,
	input logic tlr,
	input logic capture_ir,
	input logic shift_ir,
	input logic update_ir,
	input logic tdi_s,
	output jtag_instr_pkg::instr_t instr,
	output logic ir_tdo
);
	import jtag_instr_pkg::*;

	logic [`JTAG_IR_WIDTH-1:0] ir_stage;

	// shift stage, LSB out and tdi into the MSB.
	always_ff @(posedge i_clock) begin
		if (capture_ir) begin
			ir_stage <= IR_CAPTURE;
		end else if (shift_ir) begin
			ir_stage <= {tdi_s, ir_stage[`JTAG_IR_WIDTH-1:1]};
		end
	end

	assign ir_tdo = ir_stage[0];

	// active instruction, unknown codes fall back to bypass.
	always_ff @(posedge i_clock) begin
		if (i_reset || tlr) begin
			instr <= IDCODE;
		end else if (update_ir) begin
			case (ir_stage)
				IDCODE: instr <= IDCODE;
				USERCODE: instr <= USERCODE;
				default: instr <= BYPASS;
			endcase
		end
	end

endmodule

// ==== source/jtag_data_regs.sv ====
// JTAG data registers and TDO
`timescale 1ns/1ps
`include "jtag_cfg.svh"

module jtag_data_regs (
	input logic i_clock,
	input logic i_reset,
	input logic tck_fall,
	input logic capture_dr,
	input logic shift_dr,
	input logic update_dr,
	input logic ir_path,
	input jtag_instr_pkg::instr_t instr,
	input logic ir_tdo,
	input logic tdi_s,
	input logic [31:0] i_usercode,
	output logic tdo
);
	import jtag_instr_pkg::*;

	localparam logic [31:0] IDCODE_WORD = {
		`JTAG_IDCODE_VERSION,
		`JTAG_IDCODE_PART,
		`JTAG_IDCODE_MANUFACTURER,
		1'b1
	};

	logic [31:0] scan_reg; // shared by IDCODE and USERCODE.
	logic bypass_reg;
	logic in_shift_dr;
	logic sel_bypass;

	assign sel_bypass = (instr == BYPASS);

	// capture and shift of the selected path.
	always_ff @(posedge i_clock) begin
		if (capture_dr) begin
			if (sel_bypass) begin
				bypass_reg <= 1'b0;
			end else if (instr == USERCODE) begin
				scan_reg <= i_usercode; // sampled here only.
			end else begin
				scan_reg <= IDCODE_WORD;
			end
		end else if (shift_dr) begin
			if (sel_bypass) begin
				bypass_reg <= tdi_s;
			end else begin
				scan_reg <= {tdi_s, scan_reg[31:1]};
			end
		end
	end

	// spans Capture-DR through Update-DR.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			in_shift_dr <= 1'b0;
		end else if (capture_dr) begin
			in_shift_dr <= 1'b1;
		end else if (update_dr) begin
			in_shift_dr <= 1'b0;
		end
	end

	// tdo changes only on falling tck.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			tdo <= 1'b0;
		end else if (tck_fall) begin
			if (ir_path) begin
				tdo <= ir_tdo;
			end else if (in_shift_dr) begin
				tdo <= sel_bypass ? bypass_reg : scan_reg[0];
			end else begin
				tdo <= 1'b0;
			end
		end
	end

endmodule

// ==== source/jtag_tap.sv ====
// JTAG test access port
`timescale 1ns/1ps

module jtag_tap (
	input logic i_clock,
	input logic i_reset,
	input logic [31:0] i_usercode,
	input logic tck,
	input logic tms,
	input logic tdi,
	output logic tdo
);
	import jtag_instr_pkg::*;

	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic tlr;
	logic capture_ir;
	logic shift_ir;
	logic update_ir;
	logic capture_dr;
	logic shift_dr;
	logic update_dr;
	logic ir_path;
	instr_t instr;
	logic ir_tdo;

	jtag_pin_sync u_pin_sync (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.tck(tck),
		.tms(tms),
		.tdi(tdi),
		.tck_rise(tck_rise),
		.tck_fall(tck_fall),
		.tms_s(tms_s),
		.tdi_s(tdi_s)
	);

	jtag_tap_fsm u_tap_fsm (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.tck_rise(tck_rise),
		.tms_s(tms_s),
		.tlr(tlr),
		.capture_ir(capture_ir),
		.shift_ir(shift_ir),
		.update_ir(update_ir),
		.capture_dr(capture_dr),
		.shift_dr(shift_dr),
		.update_dr(update_dr),
		.ir_path(ir_path)
	);

	jtag_instr_reg u_instr_reg (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.tlr(tlr),
		.capture_ir(capture_ir),
		.shift_ir(shift_ir),
		.update_ir(update_ir),
		.tdi_s(tdi_s),
		.instr(instr),
		.ir_tdo(ir_tdo)
	);

	jtag_data_regs u_data_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.tck_fall(tck_fall),
		.capture_dr(capture_dr),
		.shift_dr(shift_dr),
		.update_dr(update_dr),
		.ir_path(ir_path),
		.instr(instr),
		.ir_tdo(ir_tdo),
		.tdi_s(tdi_s),
		.i_usercode(i_usercode),
		.tdo(tdo)
	);

endmodule

// ==== bench/jtag_tap_tb.sv ====
// JTAG TAP testbench
`timescale 1ns/1ps
`include "jtag_cfg.svh"

module jtag_tap_tb;
	import jtag_tap_pkg::*;
	import jtag_instr_pkg::*;

	localparam int HALF = 6; // i_clock cycles per tck half period.
	localparam int TCK_CLKS = 2 * HALF;
	localparam int DR_BITS = 40;
	localparam int N_IR = 10;
	localparam int N_USER = 4;
	localparam int N_TLR = 4;
	localparam int WALK_MAX = 12;
	// entry, shift bits, longest pause detour, update and idle.
	localparam int IR_SCAN_TCK = 4 + `JTAG_IR_WIDTH + 5 + 2;
	localparam int DR_SCAN_TCK = 3 + DR_BITS + 5 + 2;
	localparam int PLANNED_TCK = 1 + DR_SCAN_TCK
		+ N_IR * (IR_SCAN_TCK + DR_SCAN_TCK)
		+ N_USER * (IR_SCAN_TCK + DR_SCAN_TCK)
		+ N_TLR * (IR_SCAN_TCK + WALK_MAX + 5 + 2 + DR_SCAN_TCK);
	localparam int TIMEOUT_CYCLES = (5 + PLANNED_TCK * TCK_CLKS) * 3 / 2;
	localparam logic [31:0] IDCODE_WORD = {
		`JTAG_IDCODE_VERSION,
		`JTAG_IDCODE_PART,
		`JTAG_IDCODE_MANUFACTURER,
		1'b1
	};

	logic i_clock = 1'b0;
	logic i_reset;
	logic [31:0] i_usercode;
	logic tck;
	logic tms;
	logic tdi;
	logic tdo;

	// reference TAP model.
	tap_state_t m_state = TEST_LOGIC_RESET;
	instr_t m_instr = IDCODE;
	logic [`JTAG_IR_WIDTH-1:0] m_ir = '0;
	logic [31:0] m_dr = '0;
	logic m_bypass = 1'b0;
	logic exp_tdo = 1'b0;
	logic exp_valid = 1'b0;

	int scan_errors = 0;
	int bit_errors = 0;
	int cycle_count = 0;

	jtag_tap uut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_usercode(i_usercode),
		.tck(tck),
		.tms(tms),
		.tdi(tdi),
		.tdo(tdo)
	);

	always #4 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: scans still running after %0d clock cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	// TMS transition table of the TAP controller.
	function automatic tap_state_t next_state(input tap_state_t s, input logic t);
		case (s)
			TEST_LOGIC_RESET: return t ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE: return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN: return t ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR: return t ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR: return t ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR: return t ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR: return t ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR: return t ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR: return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN: return t ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR: return t ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR: return t ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR: return t ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR: return t ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR: return t ? UPDATE_IR : SHIFT_IR;
			default: return t ? SELECT_DR_SCAN : RUN_TEST_IDLE; // update-ir.
		endcase
	endfunction

	function automatic instr_t decode_opcode(input logic [`JTAG_IR_WIDTH-1:0] code);
		if (code == IDCODE) return IDCODE;
		else if (code == USERCODE) return USERCODE;
		else return BYPASS;
	endfunction

	// what a DR scan of din should return under a given instruction.
	function automatic logic [63:0] expected_dr(input instr_t ins, input logic [31:0] ucode,
			input logic [63:0] din);
		if (ins == BYPASS) return {din[62:0], 1'b0};
		else if (ins == USERCODE) return {din[31:0], ucode};
		else return {din[31:0], IDCODE_WORD};
	endfunction

	task automatic model_rise(input logic tms_v, input logic tdi_v);
		case (m_state)
			TEST_LOGIC_RESET: m_instr = IDCODE;
			CAPTURE_IR: m_ir = IR_CAPTURE;
			SHIFT_IR: m_ir = {tdi_v, m_ir[`JTAG_IR_WIDTH-1:1]};
			UPDATE_IR: m_instr = decode_opcode(m_ir);
			CAPTURE_DR: begin
				if (m_instr == BYPASS) m_bypass = 1'b0;
				else if (m_instr == USERCODE) m_dr = i_usercode;
				else m_dr = IDCODE_WORD;
			end
			SHIFT_DR: begin
				if (m_instr == BYPASS) m_bypass = tdi_v;
				else m_dr = {tdi_v, m_dr[31:1]};
			end
			default: ;
		endcase
		m_state = next_state(m_state, tms_v);
	endtask

	// tdo is only predicted where the output is defined.
	task automatic model_fall();
		exp_valid = 1'b1;
		case (m_state)
			SHIFT_IR: exp_tdo = m_ir[0];
			SHIFT_DR: exp_tdo = (m_instr == BYPASS) ? m_bypass : m_dr[0];
			TEST_LOGIC_RESET, RUN_TEST_IDLE: exp_tdo = 1'b0;
			default: exp_valid = 1'b0;
		endcase
	endtask

	// one full tck period, falling edge first; tdo is read just before the rise.
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge i_clock);
		#1;
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		model_fall();
		repeat (HALF) @(posedge i_clock);
		#1;
		tdo_v = tdo;
		if (exp_valid && tdo_v !== exp_tdo) begin
			$display("Mismatch tdo_bit: expected %b, actual %b", exp_tdo, tdo_v);
			bit_errors++;
		end
		tck = 1'b1;
		model_rise(tms_v, tdi_v);
		repeat (HALF - 1) @(posedge i_clock);
	endtask

	// from run-test/idle back to run-test/idle, maybe with a pause detour.
	task automatic scan(input logic is_ir, input int nbits, input logic [63:0] din,
			output logic [63:0] dout);
		int i;
		int pause_at;
		int pause_len;
		logic detour;
		logic pause_here;
		logic bit_out;
		detour = $urandom_range(1, 0);
		pause_at = $urandom_range(nbits - 2, 0);
		pause_len = $urandom_range(3, 1);
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out); // select-dr.
		if (is_ir) tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out); // capture.
		tck_cycle(1'b0, 1'b0, bit_out); // into shift.
		for (i = 0; i < nbits; i++) begin
			pause_here = detour && (i == pause_at);
			tck_cycle((i == nbits - 1) || pause_here, din[i], bit_out);
			dout[i] = bit_out;
			if (pause_here) begin
				tck_cycle(1'b0, 1'b0, bit_out); // exit1 to pause.
				repeat (pause_len - 1) tck_cycle(1'b0, 1'b0, bit_out);
				tck_cycle(1'b1, 1'b0, bit_out); // exit2.
				tck_cycle(1'b0, 1'b0, bit_out); // back to shift.
			end
		end
		tck_cycle(1'b1, 1'b0, bit_out); // update.
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic load_instr(input logic [`JTAG_IR_WIDTH-1:0] code);
		logic [63:0] dout;
		scan(1'b1, `JTAG_IR_WIDTH, {60'd0, code}, dout);
		if (dout[`JTAG_IR_WIDTH-1:0] !== IR_CAPTURE) begin
			$display("Mismatch ir_capture: expected %h, actual %h", IR_CAPTURE,
				dout[`JTAG_IR_WIDTH-1:0]);
			scan_errors++;
		end
	endtask

	task automatic check_dr(input string name, input instr_t ins);
		logic [63:0] din;
		logic [63:0] dout;
		logic [63:0] exp;
		din = {$urandom, $urandom};
		scan(1'b0, DR_BITS, din, dout);
		exp = expected_dr(ins, i_usercode, din);
		if (dout[DR_BITS-1:0] !== exp[DR_BITS-1:0]) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp[DR_BITS-1:0],
				dout[DR_BITS-1:0]);
			scan_errors++;
		end
	endtask

	initial begin
		int k;
		int walk_len;
		logic [`JTAG_IR_WIDTH-1:0] code;
		logic bit_out;
		void'($urandom(32'h158cb8e7));
		i_reset = 1'b1;
		i_usercode = '0;
		tck = 1'b1;
		tms = 1'b1;
		tdi = 1'b0;
		repeat (5) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		tck_cycle(1'b0, 1'b0, bit_out); // to run-test/idle.
		check_dr("idcode_after_reset", IDCODE);

		for (k = 0; k < N_IR; k++) begin
			if (k == 0) code = IDCODE;
			else if (k == 1) code = USERCODE;
			else if (k == 2) code = BYPASS;
			else code = $urandom_range(15, 0);
			i_usercode = $urandom;
			load_instr(code);
			check_dr("ir_select", decode_opcode(code));
		end

		for (k = 0; k < N_USER; k++) begin
			i_usercode = $urandom;
			load_instr(USERCODE);
			check_dr("usercode", USERCODE);
		end

		// usercode first, then a random walk and five tms-high cycles.
		for (k = 0; k < N_TLR; k++) begin
			load_instr(USERCODE);
			walk_len = $urandom_range(WALK_MAX, 1);
			repeat (walk_len) tck_cycle($urandom_range(1, 0), $urandom_range(1, 0), bit_out);
			repeat (5) tck_cycle(1'b1, 1'b0, bit_out);
			tck_cycle(1'b1, 1'b0, bit_out); // falls inside test-logic-reset.
			if (bit_out !== 1'b0) begin
				$display("Mismatch tlr_tdo: expected 0, actual %b", bit_out);
				scan_errors++;
			end
			tck_cycle(1'b0, 1'b0, bit_out);
			check_dr("tlr_idcode", IDCODE);
		end

		$display("Errors: %0d scan mismatches, %0d tdo bit mismatches", scan_errors,
			bit_errors);
		if (scan_errors == 0 && bit_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/jtag_tap_pkg.sv
source/jtag_instr_pkg.sv
source/jtag_pin_sync.sv
source/jtag_tap_fsm.sv
source/jtag_instr_reg.sv
source/jtag_data_regs.sv
source/jtag_tap.sv
bench/jtag_tap_tb.sv
